// File: run.sh
#!/bin/sh
# builds the icache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_icache -f vlog.f -o sim_icache
if [ $? -ne 0 ]; then
    echo "build of the testbench failed"
    exit 1
fi

./obj_dir/sim_icache > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
exit 0

// File: verification/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;

    localparam logic [63:0] PATTERN   = 64'h5a5a_c3c3_0f0f_9669;
    localparam int          ERR_BIT   = 20;
    localparam logic [1:0]  OKAY      = 2'b00;
    localparam logic [1:0]  SLVERR    = 2'b10;
    localparam int          WAIT_MAX  = 200;
    localparam int          RAND_WAIT = 20000;
    localparam int          NUM_RAND  = 200;
    localparam logic [63:0] BASE_ADDR = 64'h0000_0000_8000_0000;
    localparam logic [63:0] LINE_A    = 64'h0000_0000_8000_1040;
    localparam logic [63:0] ERR_LINE  = 64'h0000_0000_8010_2080;

    logic        clk;
    logic        rst_n;
    logic        flush_i;
    logic        ifu_arvalid;
    logic        ifu_arready;
    logic [63:0] ifu_araddr;
    logic        ifu_rvalid;
    logic        ifu_rready;
    logic [1:0]  ifu_rresp;
    logic [63:0] ifu_rdata;
    logic        mem_arvalid;
    logic        mem_arready;
    logic [63:0] mem_araddr;
    logic        mem_rvalid;
    logic        mem_rready;
    logic [63:0] mem_rdata;
    logic [1:0]  mem_rresp;
    logic        mem_rlast;
    int          ar_count;
    integer      seed;
    string       test_name;
    logic [63:0] addr_q [$];
    logic [63:0] chk_addr;
    logic [65:0] chk_exp;

    icache_top icache_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush_i     (flush_i),
        .ifu_arvalid (ifu_arvalid),
        .ifu_arready (ifu_arready),
        .ifu_araddr  (ifu_araddr),
        .ifu_rvalid  (ifu_rvalid),
        .ifu_rready  (ifu_rready),
        .ifu_rresp   (ifu_rresp),
        .ifu_rdata   (ifu_rdata),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .mem_rlast   (mem_rlast)
    );

    tb_mem_model #(.PATTERN(PATTERN), .ERR_BIT(ERR_BIT)) mem_model_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .arvalid  (mem_arvalid),
        .arready  (mem_arready),
        .araddr   (mem_araddr),
        .rvalid   (mem_rvalid),
        .rready   (mem_rready),
        .rdata    (mem_rdata),
        .rresp    (mem_rresp),
        .rlast    (mem_rlast),
        .ar_count (ar_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // **************************************************
    // helpers
    // **************************************************
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // response code above the word
    function automatic logic [65:0] expected_response(input logic [63:0] addr);
        logic [63:0] aligned;
        aligned = {addr[63:3], 3'b000};
        if (addr[ERR_BIT]) begin
            return {SLVERR, 64'h0};
        end
        return {OKAY, aligned ^ PATTERN};
    endfunction

    // four tags in each of four sets
    function automatic logic [63:0] random_addr();
        logic [31:0] r;
        logic [63:0] addr;
        r = $random(seed);
        addr = BASE_ADDR;
        addr[11:10] = r[1:0];
        addr[5:4] = r[5:4];
        addr[3] = r[6];
        addr[2:0] = r[9:7];
        // now and then an error line
        if (r[3:0] == 4'hf) begin
            addr[ERR_BIT] = 1'b1;
        end
        return addr;
    endfunction

    task automatic send_request(input logic [63:0] addr);
        int cycles;
        cycles = 0;
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= addr;
        @(posedge clk);
        while (!ifu_arready) begin
            cycles++;
            if (cycles > WAIT_MAX) begin
                stop_run("fetch request was not accepted in time");
            end
            @(posedge clk);
        end
        ifu_arvalid <= 1'b0;
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!(ifu_rvalid && ifu_rready)) begin
            cycles++;
            if (cycles > WAIT_MAX) begin
                stop_run("no fetch response arrived in time");
            end
            @(posedge clk);
        end
    endtask

    task automatic check_ar_count(input int expected);
        assert (ar_count == expected) else begin
            stop_run($sformatf("Error: %s expected ar count %0d actual %0d",
                               test_name, expected, ar_count));
        end
    endtask

    task automatic pulse_flush();
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    // **************************************************
    // response checker
    // **************************************************
    always @(posedge clk) begin
        if (rst_n) begin
            if (ifu_arvalid && ifu_arready) begin
                addr_q.push_back(ifu_araddr);
            end
            if (ifu_rvalid && ifu_rready) begin
                assert (addr_q.size() > 0) else begin
                    stop_run("a fetch response arrived with no request outstanding");
                end
                chk_addr = addr_q.pop_front();
                chk_exp = expected_response(chk_addr);
                assert (ifu_rresp == chk_exp[65:64]) else begin
                    stop_run($sformatf("Error: %s addr %h expected resp %h actual %h",
                                       test_name, chk_addr, chk_exp[65:64], ifu_rresp));
                end
                if (chk_exp[65:64] == OKAY) begin
                    assert (ifu_rdata == chk_exp[63:0]) else begin
                        stop_run($sformatf("Error: %s addr %h expected data %h actual %h",
                                           test_name, chk_addr, chk_exp[63:0], ifu_rdata));
                    end
                end
            end
        end
    end

    // **************************************************
    // stimulus
    // **************************************************
    initial begin
        int ar_start;
        int issued;
        int seen;
        int cycles;
        seed = 32'hd3d67e5f;
        test_name = "reset";
        rst_n       <= 1'b0;
        flush_i     <= 1'b0;
        ifu_arvalid <= 1'b0;
        ifu_araddr  <= '0;
        ifu_rready  <= 1'b1;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        // arready, rvalid and mem arvalid out of reset
        assert (ifu_arready && !ifu_rvalid && !mem_arvalid) else begin
            stop_run($sformatf("Error: %s expected idle flags 100 actual %b%b%b",
                               test_name, ifu_arready, ifu_rvalid, mem_arvalid));
        end

        test_name = "first_miss";
        ar_start = ar_count;
        send_request(LINE_A);
        wait_response();
        check_ar_count(ar_start + 1);

        // other word of the same line
        test_name = "hit_other_word";
        send_request(LINE_A + 64'd12);
        wait_response();
        check_ar_count(ar_start + 1);

        test_name = "error_not_cached";
        send_request(ERR_LINE);
        wait_response();
        check_ar_count(ar_start + 2);
        send_request(ERR_LINE + 64'd8);
        wait_response();
        check_ar_count(ar_start + 3);

        test_name = "flush_refetch";
        repeat (3) @(posedge clk);
        pulse_flush();
        send_request(LINE_A);
        wait_response();
        check_ar_count(ar_start + 4);

        test_name = "random_traffic";
        issued = 0;
        seen = 0;
        cycles = 0;
        ifu_arvalid <= 1'b1;
        ifu_araddr  <= random_addr();
        while (seen < NUM_RAND) begin
            @(posedge clk);
            cycles++;
            if (cycles > RAND_WAIT) begin
                stop_run("random traffic did not complete in time");
            end
            if (ifu_arvalid && ifu_arready) begin
                issued++;
                if (issued < NUM_RAND) begin
                    ifu_araddr <= random_addr();
                end else begin
                    ifu_arvalid <= 1'b0;
                end
            end
            if (ifu_rvalid && ifu_rready) begin
                seen++;
            end
            ifu_rready <= (($random(seed) & 3) != 0);
        end
        ifu_rready <= 1'b1;
        repeat (2) @(posedge clk);

        // nothing left to answer and no memory read pending
        assert (!ifu_rvalid && !mem_arvalid) else begin
            stop_run("the cache did not go idle after the random traffic");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verification/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model #(
    parameter logic [63:0] PATTERN = 64'h0,
    parameter int          ERR_BIT = 20
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        arvalid,
    output logic        arready,
    input  logic [63:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [63:0] rdata,
    output logic [1:0]  rresp,
    output logic        rlast,
    output int          ar_count
);

    logic        busy;
    logic [63:0] addr_q;

    function automatic logic [63:0] word_at(input logic [63:0] a);
        return a ^ PATTERN;
    endfunction

    // arready one cycle after arvalid, then a two beat burst
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= 2'b00;
            rlast    <= 1'b0;
            busy     <= 1'b0;
            addr_q   <= '0;
            ar_count <= 0;
        end else if (!busy) begin
            if (arvalid && arready) begin
                arready  <= 1'b0;
                busy     <= 1'b1;
                addr_q   <= araddr;
                ar_count <= ar_count + 1;
                rvalid   <= 1'b1;
                rdata    <= word_at(araddr);
                rresp    <= araddr[ERR_BIT] ? 2'b10 : 2'b00;
                rlast    <= 1'b0;
            end else begin
                arready <= arvalid;
            end
        end else if (rvalid && rready) begin
            if (!rlast) begin
                rdata <= word_at(addr_q + 64'd8);
                rlast <= 1'b1;
            end else begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             req_valid,
    input  icache_pkg::icache_addr_u         req_addr,
    output logic                             req_pop,
    input  logic                             rsp_full,
    output logic                             rsp_push,
    output logic [icache_pkg::WORD_W+1:0]    rsp_data,
    output logic                             mem_arvalid,
    input  logic                             mem_arready,
    output logic [icache_pkg::ADDR_W-1:0]    mem_araddr,
    input  logic                             mem_rvalid,
    output logic                             mem_rready,
    input  logic [icache_pkg::WORD_W-1:0]    mem_rdata,
    input  logic [1:0]                       mem_rresp,
    input  logic                             mem_rlast,
    icache_store_if.ctrl                     sif
);
    import icache_pkg::*;

    logic [2:0]        state_q;
    logic              lk_valid_q;
    icache_addr_u      lk_addr_q;
    logic [LINE_W-1:0] miss_line_q;
    logic              miss_err_q;
    logic              hit_done;
    logic              miss_done;
    logic              beat_err;
    logic [WORD_W-1:0] hit_word;
    logic [WORD_W-1:0] miss_word;

    // **************************************************
    // lookup stage
    // **************************************************
    assign hit_done  = lk_valid_q && (state_q == ST_IDLE) && sif.hit && !rsp_full;
    assign miss_done = (state_q == ST_RESP) && !rsp_full;
    assign rsp_push  = hit_done || miss_done;
    assign req_pop   = req_valid && (!lk_valid_q || rsp_push);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lk_valid_q <= 1'b0;
        end else if (req_pop) begin
            lk_valid_q <= 1'b1;
        end else if (rsp_push) begin
            lk_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            lk_addr_q <= req_addr;
        end
    end

    assign sif.rd_en   = req_pop;
    assign sif.rd_addr = req_addr;
    assign sif.wr_en   = (state_q == ST_WRITE);
    assign sif.wr_addr = lk_addr_q;
    assign sif.wr_line = miss_line_q;

    // **************************************************
    // miss fsm and memory read master
    // **************************************************
    assign beat_err = (mem_rresp != RESP_OKAY);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= ST_IDLE;
            mem_arvalid <= 1'b0;
            miss_err_q  <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (lk_valid_q && !sif.hit) begin
                        state_q     <= ST_ADDR;
                        mem_arvalid <= 1'b1;
                    end
                end
                ST_ADDR: begin
                    if (mem_arready) begin
                        state_q     <= ST_BEAT0;
                        mem_arvalid <= 1'b0;
                    end
                end
                ST_BEAT0: begin
                    if (mem_rvalid) begin
                        state_q    <= ST_BEAT1;
                        miss_err_q <= beat_err;
                    end
                end
                ST_BEAT1: begin
                    // a broken burst counts as an error too
                    if (mem_rvalid) begin
                        if (miss_err_q || beat_err || !mem_rlast) begin
                            state_q    <= ST_RESP;
                            miss_err_q <= 1'b1;
                        end else begin
                            state_q <= ST_WRITE;
                        end
                    end
                end
                ST_WRITE: begin
                    state_q <= ST_RESP;
                end
                ST_RESP: begin
                    if (!rsp_full) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q     <= ST_IDLE;
                    mem_arvalid <= 1'b0;
                end
            endcase
        end
    end

    // beat 0 is the low word
    always_ff @(posedge clk) begin
        if ((state_q == ST_BEAT0) && mem_rvalid) begin
            miss_line_q[WORD_W-1:0] <= mem_rdata;
        end
        if ((state_q == ST_BEAT1) && mem_rvalid) begin
            miss_line_q[LINE_W-1:WORD_W] <= mem_rdata;
        end
    end

    assign mem_araddr = {lk_addr_q.raw[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign mem_rready = 1'b1;

    // **************************************************
    // response
    // **************************************************
    assign hit_word  = lk_addr_q.f.word_sel ? sif.hit_line[LINE_W-1:WORD_W]
                                            : sif.hit_line[WORD_W-1:0];
    assign miss_word = lk_addr_q.f.word_sel ? miss_line_q[LINE_W-1:WORD_W]
                                            : miss_line_q[WORD_W-1:0];

    always_comb begin
        if (state_q == ST_RESP) begin
            rsp_data = {(miss_err_q ? RESP_SLVERR : RESP_OKAY), miss_word};
        end else begin
            rsp_data = {RESP_OKAY, hit_word};
        end
    end

    ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr));

endmodule

// File: verilog/icache_fifo.sv
`timescale 1ns/1ns

module icache_fifo #(
    parameter int WIDTH = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] wdata,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);
    import icache_pkg::*;

    logic [WIDTH-1:0]                mem [FIFO_DEPTH];
    logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]     count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign rdata = mem[rd_ptr];
    assign empty = (count == 0);
    assign full  = (count == FIFO_DEPTH);

    // users must honour full and empty
    fifo_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        !(push && full) && !(pop && empty));

endmodule

// File: verilog/icache_pkg.sv
package icache_pkg;

    // **************************************************
    // geometry
    // **************************************************
    localparam int ADDR_W     = 64;
    localparam int WORD_W     = 64;
    localparam int LINE_W     = 128;
    localparam int NUM_WAYS   = 2;
    localparam int NUM_SETS   = 64;
    localparam int INDEX_W    = 6;
    localparam int OFFSET_W   = 4;
    localparam int TAG_W      = 54;
    localparam int FIFO_DEPTH = 4;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // miss fsm encodings
    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_ADDR  = 3'd1;
    localparam logic [2:0] ST_BEAT0 = 3'd2;
    localparam logic [2:0] ST_BEAT1 = 3'd3;
    localparam logic [2:0] ST_WRITE = 3'd4;
    localparam logic [2:0] ST_RESP  = 3'd5;

    // fetch address, seen either whole or split into cache fields
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [TAG_W-1:0]   tag;
            logic [INDEX_W-1:0] index;
            logic               word_sel;
            logic [2:0]         byte_off;
        } f;
    } icache_addr_u;

endpackage

// File: verilog/icache_store.sv
`timescale 1ns/1ns

module icache_store (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         flush_i,
    icache_store_if.store sif
);
    import icache_pkg::*;

    logic [TAG_W-1:0]    tag_mem  [NUM_WAYS][NUM_SETS];
    logic [LINE_W-1:0]   data_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q  [NUM_WAYS];
    logic [7:0]          lfsr_q;
    logic                repl_way;
    logic [TAG_W-1:0]    rd_tag_q;
    logic [TAG_W-1:0]    way_tag_q  [NUM_WAYS];
    logic [LINE_W-1:0]   way_line_q [NUM_WAYS];
    logic [NUM_WAYS-1:0] way_valid_q;
    logic [NUM_WAYS-1:0] way_hit;
    logic [LINE_W-1:0]   hit_line;

    // **************************************************
    // replacement
    // **************************************************
    // x^8 + x^6 + x^5 + x^4 + 1, free running
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q <= 8'h5a;
        end else begin
            lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    assign repl_way = lfsr_q[0];

    // **************************************************
    // arrays
    // **************************************************
    always_ff @(posedge clk) begin
        if (sif.wr_en) begin
            tag_mem[repl_way][sif.wr_addr.f.index]  <= sif.wr_addr.f.tag;
            data_mem[repl_way][sif.wr_addr.f.index] <= sif.wr_line;
        end
    end

    // flush beats a write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (flush_i) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else if (sif.wr_en) begin
            valid_q[repl_way][sif.wr_addr.f.index] <= 1'b1;
        end
    end

    // set snapshot, held until the next read
    always_ff @(posedge clk) begin
        if (sif.rd_en) begin
            rd_tag_q <= sif.rd_addr.f.tag;
            for (int w = 0; w < NUM_WAYS; w++) begin
                way_tag_q[w]  <= tag_mem[w][sif.rd_addr.f.index];
                way_line_q[w] <= data_mem[w][sif.rd_addr.f.index];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            way_valid_q <= '0;
        end else if (sif.rd_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                way_valid_q[w] <= valid_q[w][sif.rd_addr.f.index];
            end
        end
    end

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = way_valid_q[w] && (way_tag_q[w] == rd_tag_q);
            if (way_hit[w]) begin
                hit_line = hit_line | way_line_q[w];
            end
        end
    end

    assign sif.hit      = |way_hit;
    assign sif.hit_line = hit_line;

    // a line is only ever filled after a miss on its set
    one_way_hits: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit));

endmodule

// File: verilog/icache_store_if.sv
`timescale 1ns/1ns

interface icache_store_if;
    import icache_pkg::*;

    logic              rd_en;
    icache_addr_u      rd_addr;
    logic              wr_en;
    icache_addr_u      wr_addr;
    logic [LINE_W-1:0] wr_line;
    logic              hit;
    logic [LINE_W-1:0] hit_line;

    modport ctrl (
        output rd_en, rd_addr, wr_en, wr_addr, wr_line,
        input  hit, hit_line
    );

    modport store (
        input  rd_en, rd_addr, wr_en, wr_addr, wr_line,
        output hit, hit_line
    );

endinterface

// File: verilog/icache_top.sv
`timescale 1ns/1ns

module icache_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            flush_i,
    // fetch side
    input  logic                            ifu_arvalid,
    output logic                            ifu_arready,
    input  logic [icache_pkg::ADDR_W-1:0]   ifu_araddr,
    output logic                            ifu_rvalid,
    input  logic                            ifu_rready,
    output logic [1:0]                      ifu_rresp,
    output logic [icache_pkg::WORD_W-1:0]   ifu_rdata,
    // memory side
    output logic                            mem_arvalid,
    input  logic                            mem_arready,
    output logic [icache_pkg::ADDR_W-1:0]   mem_araddr,
    input  logic                            mem_rvalid,
    output logic                            mem_rready,
    input  logic [icache_pkg::WORD_W-1:0]   mem_rdata,
    input  logic [1:0]                      mem_rresp,
    input  logic                            mem_rlast
);
    import icache_pkg::*;

    logic              req_empty;
    logic              req_full;
    logic              req_pop;
    logic [ADDR_W-1:0] req_rdata;
    logic              rsp_empty;
    logic              rsp_full;
    logic              rsp_push;
    logic [WORD_W+1:0] rsp_wdata;
    logic [WORD_W+1:0] rsp_rdata;

    icache_store_if store_bus ();

    icache_fifo #(.WIDTH(ADDR_W)) req_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (ifu_arvalid && ifu_arready),
        .pop   (req_pop),
        .wdata (ifu_araddr),
        .rdata (req_rdata),
        .empty (req_empty),
        .full  (req_full)
    );

    icache_fifo #(.WIDTH(WORD_W + 2)) rsp_fifo_i (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (rsp_push),
        .pop   (ifu_rvalid && ifu_rready),
        .wdata (rsp_wdata),
        .rdata (rsp_rdata),
        .empty (rsp_empty),
        .full  (rsp_full)
    );

    icache_ctrl ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (!req_empty),
        .req_addr    (req_rdata),
        .req_pop     (req_pop),
        .rsp_full    (rsp_full),
        .rsp_push    (rsp_push),
        .rsp_data    (rsp_wdata),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_araddr  (mem_araddr),
        .mem_rvalid  (mem_rvalid),
        .mem_rready  (mem_rready),
        .mem_rdata   (mem_rdata),
        .mem_rresp   (mem_rresp),
        .mem_rlast   (mem_rlast),
        .sif         (store_bus.ctrl)
    );

    icache_store store_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .flush_i (flush_i),
        .sif     (store_bus.store)
    );

    assign ifu_arready = !req_full;
    assign ifu_rvalid  = !rsp_empty;
    assign ifu_rresp   = rsp_rdata[WORD_W+1:WORD_W];
    assign ifu_rdata   = rsp_rdata[WORD_W-1:0];

endmodule

// File: vlog.f
verilog/icache_pkg.sv
verilog/icache_store_if.sv
verilog/icache_fifo.sv
verilog/icache_store.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
verification/tb_mem_model.sv
verification/tb_icache.sv
